// File: filelist.f
rtl/axi_wr_mux_pkg.sv
rtl/spill_register.sv
rtl/aw_rr_arbiter.sv
rtl/aw_issue_ctrl.sv
rtl/w_route_fifo.sv
rtl/w_switch.sv
rtl/b_router.sv
rtl/axi_wr_mux.sv
tests/tb_axi_wr_mux.sv

// File: tests/tb_axi_wr_mux.sv
// Testbench for the AXI write mux; the master model answers every burst with B, in order
module tb_axi_wr_mux;

  // Bursts per port for each traffic test, W hold time in cycles
  localparam int TRAFFIC_BURSTS = 12;
  localparam int HOLD_BURSTS    = 4;
  localparam int FAIR_BURSTS    = 4;
  localparam int HOLD_CYCLES    = 60;
  localparam int IDLE_CYCLES    = 4;
  // Watchdog limit from the summed test lengths
  localparam int WATCHDOG_CYCLES =
    (TRAFFIC_BURSTS + HOLD_BURSTS + FAIR_BURSTS + HOLD_CYCLES + IDLE_CYCLES) * 40;

  // Grant record, taken at the slave AW handshake
  typedef struct packed {
    axi_wr_mux_pkg::port_idx_t           port;
    logic [axi_wr_mux_pkg::MST_ID_W-1:0] id;
    logic [axi_wr_mux_pkg::ADDR_W-1:0]   addr;
    logic [axi_wr_mux_pkg::LEN_W-1:0]    len;
    logic [7:0]                          seq;
  } grant_t;

  logic clk_i;
  logic rst_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_aw_valid_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_aw_ready_o;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::SLV_ID_W-1:0] slv_aw_id_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::ADDR_W-1:0]   slv_aw_addr_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::LEN_W-1:0]    slv_aw_len_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_w_valid_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_w_ready_o;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::DATA_W-1:0]   slv_w_data_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::STRB_W-1:0]   slv_w_strb_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_w_last_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_b_valid_o;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                               slv_b_ready_i;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::SLV_ID_W-1:0] slv_b_id_o;
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::RESP_W-1:0]   slv_b_resp_o;
  logic                                mst_aw_valid_o;
  logic                                mst_aw_ready_i;
  logic [axi_wr_mux_pkg::MST_ID_W-1:0] mst_aw_id_o;
  logic [axi_wr_mux_pkg::ADDR_W-1:0]   mst_aw_addr_o;
  logic [axi_wr_mux_pkg::LEN_W-1:0]    mst_aw_len_o;
  logic                                mst_w_valid_o;
  logic                                mst_w_ready_i;
  logic [axi_wr_mux_pkg::DATA_W-1:0]   mst_w_data_o;
  logic [axi_wr_mux_pkg::STRB_W-1:0]   mst_w_strb_o;
  logic                                mst_w_last_o;
  logic                                mst_b_valid_i;
  logic                                mst_b_ready_o;
  logic [axi_wr_mux_pkg::MST_ID_W-1:0] mst_b_id_i;
  logic [axi_wr_mux_pkg::RESP_W-1:0]   mst_b_resp_i;

  // Scoreboard state
  int     seed = 85372;
  int     pass_cnt;
  int     fail_cnt;
  int     b_done;
  int     b_target;
  int     ports_done;
  int     open_cnt;
  int     max_open;
  int     w_beat;
  bit     stall_on;
  bit     w_hold;
  grant_t aw_exp_q[$];
  grant_t w_exp_q[$];
  grant_t b_pend_q[$];
  // Burst whose B the master model is offering
  grant_t b_cur;
  axi_wr_mux_pkg::w_chan_t             w_got_q[$];
  logic [axi_wr_mux_pkg::SLV_ID_W-1:0] exp_b_q[axi_wr_mux_pkg::NUM_PORTS][$];
  int                                  len_q[axi_wr_mux_pkg::NUM_PORTS][$];
  logic [7:0]                          w_seq[axi_wr_mux_pkg::NUM_PORTS];
  logic [7:0]                          gnt_seq[axi_wr_mux_pkg::NUM_PORTS];
  // Ports granted while a given port waited
  logic [axi_wr_mux_pkg::NUM_PORTS-1:0] passed[axi_wr_mux_pkg::NUM_PORTS];

  axi_wr_mux u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Check helpers
  // --------------------------------------------------------------------------
  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    assert (expected === actual) pass_cnt++;
    else begin
      fail_cnt++;
      $display("mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) pass_cnt++;
    else begin
      fail_cnt++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  // Beat payload from port, burst number and beat number
  function automatic logic [31:0] beat_data(input int p, input logic [7:0] seq, input int beat);
    return {8'(p), seq, 16'(beat)};
  endfunction

  function automatic logic [3:0] beat_strb(input int p);
    return 4'hF ^ 4'(p);
  endfunction

  // --------------------------------------------------------------------------
  // Slave side drivers
  // --------------------------------------------------------------------------
  task automatic send_aws(input int p, input int nb);
    logic [axi_wr_mux_pkg::LEN_W-1:0] len;
    for (int b = 0; b < nb; b++) begin
      @(negedge clk_i);
      len = 8'($unsigned($random(seed)) % 4);
      slv_aw_valid_i[p] = 1'b1;
      slv_aw_id_i[p]    = 4'($random(seed));
      slv_aw_addr_i[p]  = $random(seed);
      slv_aw_len_i[p]   = len;
      exp_b_q[p].push_back(slv_aw_id_i[p]);
      len_q[p].push_back(int'(len));
      // Valid stays up until taken
      do @(posedge clk_i); while (!slv_aw_ready_o[p]);
    end
    @(negedge clk_i);
    slv_aw_valid_i[p] = 1'b0;
  endtask

  task automatic send_ws(input int p, input int nb);
    int len;
    for (int b = 0; b < nb; b++) begin
      while (len_q[p].size() == 0) @(posedge clk_i);
      len = len_q[p].pop_front();
      for (int k = 0; k <= len; k++) begin
        @(negedge clk_i);
        slv_w_valid_i[p] = 1'b1;
        slv_w_data_i[p]  = beat_data(p, w_seq[p], k);
        slv_w_strb_i[p]  = beat_strb(p);
        slv_w_last_i[p]  = (k == len);
        do @(posedge clk_i); while (!slv_w_ready_o[p]);
      end
      w_seq[p]++;
      // No AW queued yet, so the old last beat must not linger
      if (len_q[p].size() == 0) begin
        @(negedge clk_i);
        slv_w_valid_i[p] = 1'b0;
      end
    end
  endtask

  task automatic drive_port(input int p, input int nb);
    fork
      send_aws(p, nb);
      send_ws(p, nb);
    join
    ports_done++;
  endtask

  // --------------------------------------------------------------------------
  // Test sequencing
  // --------------------------------------------------------------------------
  task automatic check_idle(input int cycles);
    int fail0;
    fail0 = fail_cnt;
    repeat (cycles) begin
      @(posedge clk_i);
      compare_value("mst_aw_valid_o", 0, mst_aw_valid_o);
      compare_value("mst_w_valid_o", 0, mst_w_valid_o);
      compare_value("slv_b_valid_o", 0, slv_b_valid_o);
    end
    $display("test reset finished with %0d failures", fail_cnt - fail0);
  endtask

  task automatic run_test(input string name, input int nb, input bit stalls, input int hold);
    int fail0;
    fail0      = fail_cnt;
    stall_on   = stalls;
    w_hold     = (hold > 0);
    max_open   = 0;
    ports_done = 0;
    b_target   = b_done + axi_wr_mux_pkg::NUM_PORTS * nb;
    for (int p = 0; p < axi_wr_mux_pkg::NUM_PORTS; p++) begin
      automatic int pp = p;
      fork
        drive_port(pp, nb);
      join_none
    end
    if (hold > 0) begin
      repeat (hold) @(posedge clk_i);
      compare_value("open AW count at W hold end", axi_wr_mux_pkg::MAX_W_TRANS, max_open);
      // Full W spill blocks every slave W port
      compare_value("slv_w_ready_o", 0, slv_w_ready_o);
      w_hold = 1'b0;
    end
    while (!(ports_done == axi_wr_mux_pkg::NUM_PORTS && b_done == b_target)) @(negedge clk_i);
    require(aw_exp_q.size() == 0 && w_exp_q.size() == 0 && w_got_q.size() == 0,
            "granted AWs or master W beats left unmatched");
    $display("test %s finished with %0d failures", name, fail_cnt - fail0);
  endtask

  // Master ready stalls, W hold and slave B ready
  initial begin
    forever begin
      @(negedge clk_i);
      mst_aw_ready_i = stall_on ? (($random(seed) & 3) != 0) : 1'b1;
      mst_w_ready_i  = w_hold ? 1'b0 : (stall_on ? (($random(seed) & 3) != 0) : 1'b1);
      slv_b_ready_i  = stall_on ? 4'($random(seed)) : '1;
    end
  end

  // Master B responder, one response per completed burst
  initial begin
    forever begin
      @(negedge clk_i);
      if (b_pend_q.size() > 0) begin
        b_cur         = b_pend_q.pop_front();
        mst_b_valid_i = 1'b1;
        mst_b_id_i    = b_cur.id;
        mst_b_resp_i  = 2'($random(seed));
        do @(posedge clk_i); while (!mst_b_ready_o);
      end else begin
        mst_b_valid_i = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Monitors
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    grant_t                    g;
    axi_wr_mux_pkg::port_idx_t p;
    axi_wr_mux_pkg::w_chan_t   wb;
    if (rst_i) begin
      for (int q = 0; q < axi_wr_mux_pkg::NUM_PORTS; q++) passed[q] = '0;
    end else begin
      // Slave grants give the expected AW and W order
      for (int q = 0; q < axi_wr_mux_pkg::NUM_PORTS; q++) begin
        if (slv_aw_valid_i[q] && slv_aw_ready_o[q]) begin
          g = '{port: q, id: {2'(q), slv_aw_id_i[q]}, addr: slv_aw_addr_i[q],
                len: slv_aw_len_i[q], seq: gnt_seq[q]};
          gnt_seq[q]++;
          aw_exp_q.push_back(g);
          w_exp_q.push_back(g);
          open_cnt++;
          require(open_cnt <= axi_wr_mux_pkg::MAX_W_TRANS, "too many open write bursts");
          if (open_cnt > max_open) max_open = open_cnt;
        end
      end
      if (|(slv_w_valid_i & slv_w_ready_o & slv_w_last_i)) open_cnt--;
      // Fairness, a waiting port sees each other port granted at most once
      for (int q = 0; q < axi_wr_mux_pkg::NUM_PORTS; q++) begin
        if (slv_aw_valid_i[q] && !slv_aw_ready_o[q]) begin
          for (int r = 0; r < axi_wr_mux_pkg::NUM_PORTS; r++) begin
            if (slv_aw_ready_o[r]) begin
              require(!passed[q][r],
                      $sformatf("port %0d granted twice while port %0d waited", r, q));
              passed[q][r] = 1'b1;
            end
          end
        end else begin
          passed[q] = '0;
        end
      end
      // Master AW, ID prepend and pass-through
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        require(aw_exp_q.size() > 0, "AW reached the master without a slave grant");
        if (aw_exp_q.size() > 0) begin
          g = aw_exp_q.pop_front();
          compare_value("mst_aw_id_o", g.id, mst_aw_id_o);
          compare_value("mst_aw_addr_o", g.addr, mst_aw_addr_o);
          compare_value("mst_aw_len_o", g.len, mst_aw_len_o);
        end
      end
      // Master W beats, a locked AW lets its burst start before the slave AW handshake
      if (mst_w_valid_o && mst_w_ready_i) begin
        w_got_q.push_back({mst_w_data_o, mst_w_strb_o, mst_w_last_o});
      end
      // Bursts in grant order
      while (w_got_q.size() > 0 && w_exp_q.size() > 0) begin
        g  = w_exp_q[0];
        wb = w_got_q.pop_front();
        compare_value("mst_w_data_o", beat_data(g.port, g.seq, w_beat), wb.data);
        compare_value("mst_w_strb_o", beat_strb(g.port), wb.strb);
        compare_value("mst_w_last_o", (w_beat == g.len), wb.last);
        if (w_beat == g.len) begin
          void'(w_exp_q.pop_front());
          b_pend_q.push_back(g);
          w_beat = 0;
        end else begin
          w_beat++;
        end
      end
      // B routing to the port that issued the write
      if (mst_b_valid_i) begin
        p = b_cur.port;
        compare_value("slv_b_valid_o", 4'b1 << p, slv_b_valid_o);
        compare_value("mst_b_ready_o", slv_b_ready_i[p], mst_b_ready_o);
        compare_value("slv_b_id_o", mst_b_id_i[axi_wr_mux_pkg::SLV_ID_W-1:0], slv_b_id_o[p]);
        compare_value("slv_b_resp_o", mst_b_resp_i, slv_b_resp_o[p]);
      end
      for (int q = 0; q < axi_wr_mux_pkg::NUM_PORTS; q++) begin
        if (slv_b_valid_o[q] && slv_b_ready_i[q]) begin
          require(exp_b_q[q].size() > 0, $sformatf("port %0d got B without a write", q));
          if (exp_b_q[q].size() > 0) begin
            compare_value("slv_b_id_o", exp_b_q[q].pop_front(), slv_b_id_o[q]);
          end
          b_done++;
        end
      end
    end
  end

  // At most one AW grant and one B valid per cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
                   $onehot0(slv_aw_ready_o) && $onehot0(slv_b_valid_o))
  else begin
    fail_cnt++;
    $display("error at %0t: more than one slave AW ready or B valid", $time);
  end

  // Reset clears the master side valids
  assert property (@(posedge clk_i) rst_i |=> (!mst_aw_valid_o && !mst_w_valid_o))
  else begin
    fail_cnt++;
    $display("error at %0t: master valid high right after reset", $time);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    rst_i          = 1'b1;
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '1;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    for (int q = 0; q < axi_wr_mux_pkg::NUM_PORTS; q++) begin
      w_seq[q]   = '0;
      gnt_seq[q] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_idle(IDLE_CYCLES);
    run_test("traffic", TRAFFIC_BURSTS, 1'b1, 0);
    run_test("w_limit", HOLD_BURSTS, 1'b0, HOLD_CYCLES);
    run_test("fairness", FAIR_BURSTS, 1'b0, 0);
    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/axi_wr_mux.sv
// AXI4 write mux; slave IDs widen by the port index, master must echo the full ID on B
module axi_wr_mux (
  input  logic                                                         clk_i,
  input  logic                                                         rst_i,
  // Slave side AW, packed per port
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_aw_valid_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_aw_ready_o,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::SLV_ID_W-1:0] slv_aw_id_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::ADDR_W-1:0]   slv_aw_addr_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::LEN_W-1:0]    slv_aw_len_i,
  // Slave side W
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_w_valid_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_w_ready_o,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::DATA_W-1:0]   slv_w_data_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::STRB_W-1:0]   slv_w_strb_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_w_last_i,
  // Slave side B
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_b_valid_o,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         slv_b_ready_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::SLV_ID_W-1:0] slv_b_id_o,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::RESP_W-1:0]   slv_b_resp_o,
  // Master side AW
  output logic                                                         mst_aw_valid_o,
  input  logic                                                         mst_aw_ready_i,
  output logic [axi_wr_mux_pkg::MST_ID_W-1:0]                          mst_aw_id_o,
  output logic [axi_wr_mux_pkg::ADDR_W-1:0]                            mst_aw_addr_o,
  output logic [axi_wr_mux_pkg::LEN_W-1:0]                             mst_aw_len_o,
  // Master side W
  output logic                                                         mst_w_valid_o,
  input  logic                                                         mst_w_ready_i,
  output logic [axi_wr_mux_pkg::DATA_W-1:0]                            mst_w_data_o,
  output logic [axi_wr_mux_pkg::STRB_W-1:0]                            mst_w_strb_o,
  output logic                                                         mst_w_last_o,
  // Master side B
  input  logic                                                         mst_b_valid_i,
  output logic                                                         mst_b_ready_o,
  input  logic [axi_wr_mux_pkg::MST_ID_W-1:0]                          mst_b_id_i,
  input  logic [axi_wr_mux_pkg::RESP_W-1:0]                            mst_b_resp_i
);

  // Arbiter to issue control
  logic                      arb_valid;
  logic                      arb_ready;
  axi_wr_mux_pkg::aw_chan_t  arb_aw;
  axi_wr_mux_pkg::port_idx_t arb_idx;
  // AW spill input handshake
  logic                      aw_spill_valid;
  logic                      aw_spill_ready;
  axi_wr_mux_pkg::aw_chan_t  mst_aw_chan;
  // Routing FIFO
  logic                      fifo_push;
  logic                      fifo_pop;
  logic                      fifo_full;
  logic                      fifo_empty;
  axi_wr_mux_pkg::port_idx_t head_idx;
  // W switch to W spill
  logic                      w_sw_valid;
  logic                      w_sw_ready;
  axi_wr_mux_pkg::w_chan_t   w_sw_chan;
  axi_wr_mux_pkg::w_chan_t   mst_w_chan;

  // --------------------------------------------------------------------------
  // AW path
  // --------------------------------------------------------------------------
  aw_rr_arbiter u_aw_arb (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (slv_aw_valid_i),
    .gnt_o   (slv_aw_ready_o),
    .id_i    (slv_aw_id_i),
    .addr_i  (slv_aw_addr_i),
    .len_i   (slv_aw_len_i),
    .valid_o (arb_valid),
    .ready_i (arb_ready),
    .aw_o    (arb_aw),
    .idx_o   (arb_idx)
  );

  aw_issue_ctrl u_aw_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .arb_valid_i   (arb_valid),
    .arb_ready_o   (arb_ready),
    .spill_valid_o (aw_spill_valid),
    .spill_ready_i (aw_spill_ready),
    .fifo_full_i   (fifo_full),
    .fifo_push_o   (fifo_push)
  );

  spill_register #(.payload_t(axi_wr_mux_pkg::aw_chan_t)) u_aw_spill (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (aw_spill_valid),
    .ready_o (aw_spill_ready),
    .data_i  (arb_aw),
    .valid_o (mst_aw_valid_o),
    .ready_i (mst_aw_ready_i),
    .data_o  (mst_aw_chan)
  );

  assign mst_aw_id_o   = mst_aw_chan.id;
  assign mst_aw_addr_o = mst_aw_chan.addr;
  assign mst_aw_len_o  = mst_aw_chan.len;

  // --------------------------------------------------------------------------
  // W path, steered by the AW grant order
  // --------------------------------------------------------------------------
  w_route_fifo u_w_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .data_i  (arb_idx),
    .pop_i   (fifo_pop),
    .data_o  (head_idx),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  w_switch u_w_sw (
    .head_idx_i  (head_idx),
    .empty_i     (fifo_empty),
    .slv_valid_i (slv_w_valid_i),
    .slv_ready_o (slv_w_ready_o),
    .slv_data_i  (slv_w_data_i),
    .slv_strb_i  (slv_w_strb_i),
    .slv_last_i  (slv_w_last_i),
    .valid_o     (w_sw_valid),
    .ready_i     (w_sw_ready),
    .chan_o      (w_sw_chan),
    .pop_o       (fifo_pop)
  );

  spill_register #(.payload_t(axi_wr_mux_pkg::w_chan_t)) u_w_spill (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (w_sw_valid),
    .ready_o (w_sw_ready),
    .data_i  (w_sw_chan),
    .valid_o (mst_w_valid_o),
    .ready_i (mst_w_ready_i),
    .data_o  (mst_w_chan)
  );

  assign mst_w_data_o = mst_w_chan.data;
  assign mst_w_strb_o = mst_w_chan.strb;
  assign mst_w_last_o = mst_w_chan.last;

  // --------------------------------------------------------------------------
  // B path, combinational
  // --------------------------------------------------------------------------
  b_router u_b_rt (
    .mst_valid_i (mst_b_valid_i),
    .mst_ready_o (mst_b_ready_o),
    .mst_id_i    (mst_b_id_i),
    .mst_resp_i  (mst_b_resp_i),
    .slv_valid_o (slv_b_valid_o),
    .slv_ready_i (slv_b_ready_i),
    .slv_id_o    (slv_b_id_o),
    .slv_resp_o  (slv_b_resp_o)
  );

endmodule

// File: rtl/b_router.sv
// B demultiplexer; the upper MST_ID_W-SLV_ID_W ID bits must name a valid port
module b_router (
  input  logic                                                        mst_valid_i,
  output logic                                                        mst_ready_o,
  input  logic [axi_wr_mux_pkg::MST_ID_W-1:0]                         mst_id_i,
  input  logic [axi_wr_mux_pkg::RESP_W-1:0]                           mst_resp_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                        slv_valid_o,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                        slv_ready_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::SLV_ID_W-1:0] slv_id_o,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::RESP_W-1:0]   slv_resp_o
);

  axi_wr_mux_pkg::port_idx_t dst_idx;

  // Port index sits right above the slave ID
  assign dst_idx = mst_id_i[axi_wr_mux_pkg::SLV_ID_W +: axi_wr_mux_pkg::PORT_IDX_W];

  assign slv_valid_o = mst_valid_i ? (axi_wr_mux_pkg::NUM_PORTS'(1) << dst_idx) : '0;
  assign mst_ready_o = slv_ready_i[dst_idx];

  // Stripped ID and response fan out to every port
  assign slv_id_o   = {axi_wr_mux_pkg::NUM_PORTS{mst_id_i[axi_wr_mux_pkg::SLV_ID_W-1:0]}};
  assign slv_resp_o = {axi_wr_mux_pkg::NUM_PORTS{mst_resp_i}};

endmodule

// File: rtl/w_switch.sv
// W multiplexer; only the port at the FIFO head may pass beats, head is popped on its last beat
module w_switch (
  input  axi_wr_mux_pkg::port_idx_t                                   head_idx_i,
  input  logic                                                        empty_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                        slv_valid_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                        slv_ready_o,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::DATA_W-1:0] slv_data_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::STRB_W-1:0] slv_strb_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                        slv_last_i,
  output logic                                                        valid_o,
  input  logic                                                        ready_i,
  output axi_wr_mux_pkg::w_chan_t                                     chan_o,
  output logic                                                        pop_o
);

  // Payload follows the head unconditionally
  assign chan_o.data = slv_data_i[head_idx_i];
  assign chan_o.strb = slv_strb_i[head_idx_i];
  assign chan_o.last = slv_last_i[head_idx_i];

  // Nothing routed without a granted AW
  assign valid_o = !empty_i && slv_valid_i[head_idx_i];

  assign slv_ready_o = (!empty_i && ready_i) ?
                       (axi_wr_mux_pkg::NUM_PORTS'(1) << head_idx_i) : '0;

  // Burst done, next grant takes over
  assign pop_o = valid_o && ready_i && chan_o.last;

endmodule

// File: rtl/w_route_fifo.sv
// Port index FIFO, depth MAX_W_TRANS; not fall-through, push while full and pop while empty are ignored
module w_route_fifo (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      push_i,
  input  axi_wr_mux_pkg::port_idx_t data_i,
  input  logic                      pop_i,
  output axi_wr_mux_pkg::port_idx_t data_o,
  output logic                      full_o,
  output logic                      empty_o
);

  axi_wr_mux_pkg::port_idx_t           mem [axi_wr_mux_pkg::MAX_W_TRANS];
  logic [axi_wr_mux_pkg::W_PTR_W-1:0]  wr_ptr_q;
  logic [axi_wr_mux_pkg::W_PTR_W-1:0]  rd_ptr_q;
  logic [axi_wr_mux_pkg::W_CNT_W-1:0]  cnt_q;
  logic                                do_push;
  logic                                do_pop;

  assign full_o  = (cnt_q == axi_wr_mux_pkg::W_CNT_W'(axi_wr_mux_pkg::MAX_W_TRANS));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: rtl/aw_issue_ctrl.sv
// AW issue control; one FIFO push per granted AW, no new grant while the routing FIFO is full
module aw_issue_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic arb_valid_i,
  output logic arb_ready_o,
  output logic spill_valid_o,
  input  logic spill_ready_i,
  input  logic fifo_full_i,
  output logic fifo_push_o
);

  // Set while an offered AW waits on the spill after its FIFO push
  logic lock_q;
  logic lock_d;

  always_comb begin
    lock_d        = lock_q;
    fifo_push_o   = 1'b0;
    spill_valid_o = 1'b0;
    arb_ready_o   = 1'b0;
    if (lock_q) begin
      // Index already pushed, only the AW is left to hand over
      spill_valid_o = 1'b1;
      if (spill_ready_i) begin
        arb_ready_o = 1'b1;
        lock_d      = 1'b0;
      end
    end else if (arb_valid_i && !fifo_full_i) begin
      // New grant, routing entry goes in right away
      spill_valid_o = 1'b1;
      fifo_push_o   = 1'b1;
      if (spill_ready_i) begin
        arb_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

endmodule

// File: rtl/aw_rr_arbiter.sv
// Round-robin AW arbiter; slave valids must stay high until ready, as AXI requires
module aw_rr_arbiter (
  input  logic                                                         clk_i,
  input  logic                                                         rst_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         req_i,
  output logic [axi_wr_mux_pkg::NUM_PORTS-1:0]                         gnt_o,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::SLV_ID_W-1:0] id_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::ADDR_W-1:0]   addr_i,
  input  logic [axi_wr_mux_pkg::NUM_PORTS-1:0][axi_wr_mux_pkg::LEN_W-1:0]    len_i,
  output logic                                                         valid_o,
  input  logic                                                         ready_i,
  output axi_wr_mux_pkg::aw_chan_t                                     aw_o,
  output axi_wr_mux_pkg::port_idx_t                                    idx_o
);

  // Last port that completed a handshake
  axi_wr_mux_pkg::port_idx_t rr_q;
  // Offer held while not taken
  logic                      lock_q;
  axi_wr_mux_pkg::port_idx_t lock_idx_q;
  // Search result for the unlocked case
  axi_wr_mux_pkg::port_idx_t sel_idx;
  axi_wr_mux_pkg::port_idx_t cand;
  logic                      found;

  // First requester after rr_q, wrapping around
  always_comb begin
    sel_idx = rr_q;
    found   = 1'b0;
    cand    = rr_q;
    for (int unsigned i = 1; i <= axi_wr_mux_pkg::NUM_PORTS; i++) begin
      cand = axi_wr_mux_pkg::port_idx_t'((rr_q + i) % axi_wr_mux_pkg::NUM_PORTS);
      if (!found && req_i[cand]) begin
        sel_idx = cand;
        found   = 1'b1;
      end
    end
  end

  assign idx_o   = lock_q ? lock_idx_q : sel_idx;
  // No requester leaves sel_idx on an idle port, so valid drops out naturally
  assign valid_o = req_i[idx_o];

  // ID prepend, port index goes above the slave ID
  assign aw_o.id   = {idx_o, id_i[idx_o]};
  assign aw_o.addr = addr_i[idx_o];
  assign aw_o.len  = len_i[idx_o];

  assign gnt_o = (valid_o && ready_i) ?
                 (axi_wr_mux_pkg::NUM_PORTS'(1) << idx_o) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Port 0 wins first
      rr_q       <= axi_wr_mux_pkg::port_idx_t'(axi_wr_mux_pkg::NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid_o && ready_i) begin
      rr_q   <= idx_o;
      lock_q <= 1'b0;
    end else if (valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= idx_o;
    end
  end

endmodule

// File: rtl/spill_register.sv
// Two-entry elastic stage; ready_o comes from its own fill state only, one cycle in to out
module spill_register #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Slot A drives the output, slot B catches an input during an output stall
  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;
  logic     take_in;
  logic     give_out;

  assign ready_o  = !b_full_q;
  assign valid_o  = a_full_q;
  assign data_o   = a_data_q;
  assign take_in  = valid_i && ready_o;
  assign give_out = a_full_q && ready_i;

  // ----------------------------------------------------------------------------
  // Fill state
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (b_full_q) begin
      // B moves up to A, A stays full
      if (give_out) begin
        b_full_q <= 1'b0;
      end
    end else if (a_full_q) begin
      if (take_in && !give_out) begin
        b_full_q <= 1'b1;
      end else if (!take_in && give_out) begin
        a_full_q <= 1'b0;
      end
    end else if (take_in) begin
      a_full_q <= 1'b1;
    end
  end

  // Payload moves with the same conditions
  always_ff @(posedge clk_i) begin
    if (b_full_q) begin
      if (give_out) begin
        a_data_q <= b_data_q;
      end
    end else if (take_in) begin
      if (a_full_q && !give_out) begin
        b_data_q <= data_i;
      end else begin
        a_data_q <= data_i;
      end
    end
  end

endmodule

// File: rtl/axi_wr_mux_pkg.sv
// Shared widths and channel structs; NUM_PORTS and MAX_W_TRANS are assumed to be powers of two
package axi_wr_mux_pkg;

  // --------------------------------------------------------------------------
  // Port count and ID widths
  // --------------------------------------------------------------------------
  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned PORT_IDX_W = $clog2(NUM_PORTS);
  localparam int unsigned SLV_ID_W   = 4;
  // Master ID carries the port index above the slave ID
  localparam int unsigned MST_ID_W   = SLV_ID_W + PORT_IDX_W;

  // Payload widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned RESP_W = 2;

  // Granted AWs whose W burst is still open
  localparam int unsigned MAX_W_TRANS = 8;
  // Routing FIFO pointer and fill counter widths
  localparam int unsigned W_PTR_W     = $clog2(MAX_W_TRANS);
  localparam int unsigned W_CNT_W     = $clog2(MAX_W_TRANS + 1);

  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // AW payload on the master side, 46 bits
  typedef struct packed {
    logic [MST_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } aw_chan_t;

  // W payload, identical on both sides, 37 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

endpackage
